/* verification/dma_l2r_tb.sv */
/*
 * Directed tests for the DMA read path against a Wishbone memory model.
 * Inputs change on the falling edge; flits and acked bus cycles are
 * logged on the rising edge. Each wait gives up after TIMEOUT cycles.
 */

`default_nettype none

`include "dma_config.svh"

module dma_l2r_tb;

  localparam int TIMEOUT = 2000;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       desc_req;
  dma_pkg::dma_desc_t         desc;
  logic                       desc_ack;
  dma_pkg::wb_req_t           wb_req;
  logic [`DMA_DATA_WIDTH-1:0] wb_dat;
  logic                       wb_ack;
  logic                       flit_valid;
  dma_pkg::dma_flit_t         flit;
  logic                       flit_ready;
  logic [3:0]                 wait_states;

  logic [31:0]        lcg_state;
  int                 mismatch_cnt;
  int                 other_err_cnt;
  // Accepted flits and acked bus cycles of the running transfer
  dma_pkg::dma_flit_t flit_log[$];
  dma_pkg::wb_req_t   wb_log[$];
  // Per acked bus cycle, stb was low since the previous acked cycle
  bit                 gap_log[$];
  logic               prev_stb;
  logic [2:0]         last_cti;
  logic               stb_gap;

  always #50 clk = ~clk;

  dma_l2r_top DUT (
    .clk          (clk),
    .rst          (rst),
    .desc_req_i   (desc_req),
    .desc_i       (desc),
    .desc_ack_o   (desc_ack),
    .wb_req_o     (wb_req),
    .wb_dat_i     (wb_dat),
    .wb_ack_i     (wb_ack),
    .flit_valid_o (flit_valid),
    .flit_o       (flit),
    .flit_ready_i (flit_ready)
  );

  wb_mem_model u_mem (
    .clk           (clk),
    .rst           (rst),
    .wb_req_i      (wb_req),
    .wait_states_i (wait_states),
    .wb_dat_o      (wb_dat),
    .wb_ack_o      (wb_ack)
  );

  //////////////////////////////
  // Monitor

  always @(posedge clk) begin
    if (rst) begin
      prev_stb <= 1'b0;
      last_cti <= 3'b000;
      stb_gap  <= 1'b1;
    end else begin
      if (flit_valid && flit_ready) begin
        flit_log.push_back(flit);
      end
      if (wb_req.stb && wb_ack) begin
        wb_log.push_back(wb_req);
        gap_log.push_back(stb_gap);
        last_cti <= wb_req.cti;
        stb_gap  <= 1'b0;
      end else if (!wb_req.stb) begin
        // Bus idle, the next acked word follows a pause
        stb_gap <= 1'b1;
      end
      // A burst may only pause after a cycle that announced its end
      if (prev_stb && !wb_req.stb && last_cti != 3'b111) begin
        $display("error: stb dropped after a bus cycle with cti %b", last_cti);
        other_err_cnt++;
      end
      prev_stb <= wb_req.stb;
    end
  end

  //////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory model contents
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return adr ^ 32'hA5A5_0000;
  endfunction

  // Header 0 layout: tile in 31:24, size in 7:0
  function automatic logic [31:0] header0(input dma_pkg::dma_desc_t d);
    logic [31:0] w;
    w = 32'h0;
    w[31:24] = d.dest_tile;
    w[7:0]   = d.size;
    return w;
  endfunction

  task automatic check_flit(input string name, input dma_pkg::dma_flit_t exp,
                            input dma_pkg::dma_flit_t act);
    if (exp !== act) begin
      $display("mismatch in %s: expected last %b data %h, actual last %b data %h",
               name, exp.last, exp.data, act.last, act.data);
      mismatch_cnt++;
    end
  endtask

  task automatic check_wb_req(input string name, input dma_pkg::wb_req_t exp,
                              input dma_pkg::wb_req_t act);
    if (exp !== act) begin
      $write("mismatch in %s: expected adr %h sel %b cyc %b we %b cti %b, ",
             name, exp.adr, exp.sel, exp.cyc, exp.we, exp.cti);
      $display("actual adr %h sel %b cyc %b we %b cti %b",
               act.adr, act.sel, act.cyc, act.we, act.cti);
      mismatch_cnt++;
    end
  endtask

  task automatic make_random_desc(output dma_pkg::dma_desc_t d);
    lcg_state   = lcg_next(lcg_state);
    d.dest_tile = lcg_state[31:24];
    lcg_state   = lcg_next(lcg_state);
    d.raddr     = lcg_state;
    lcg_state   = lcg_next(lcg_state);
    d.laddr     = {lcg_state[31:2], 2'b00};
    lcg_state   = lcg_next(lcg_state);
    d.size      = 8'(lcg_state[31:16] % 24) + 8'd1;
  endtask

  // Full four-phase cycle, optionally with random ready stalls
  task automatic run_desc(input string name, input dma_pkg::dma_desc_t d, input bit stall);
    int cycles;
    int first_valid;
    bit acked;
    cycles      = 0;
    first_valid = -1;
    acked       = 1'b0;
    flit_log.delete();
    wb_log.delete();
    gap_log.delete();
    if (desc_ack) begin
      $display("error in %s: ack still high when a new descriptor is offered", name);
      other_err_cnt++;
    end
    desc     = d;
    desc_req = 1'b1;
    while (!acked && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (flit_valid && first_valid < 0) begin
        first_valid = cycles;
      end
      if (desc_ack) begin
        acked = 1'b1;
        // Ack only after the last flit went out
        if (flit_log.size() != int'(d.size) + 2) begin
          $display("mismatch in %s flits at ack: expected %0d, actual %0d",
                   name, int'(d.size) + 2, flit_log.size());
          mismatch_cnt++;
        end
      end else if (stall) begin
        lcg_state  = lcg_next(lcg_state);
        flit_ready = lcg_state[31];
      end
    end
    flit_ready = 1'b1;
    if (!acked) begin
      $display("error in %s: no ack within %0d cycles", name, TIMEOUT);
      other_err_cnt++;
    end
    // One cycle to start, header 0 in the cycle after
    if (first_valid != 2) begin
      $display("mismatch in %s first flit cycle: expected 2, actual %0d", name, first_valid);
      mismatch_cnt++;
    end
    desc_req = 1'b0;
    @(negedge clk);
    if (acked && desc_ack) begin
      $display("error in %s: ack did not drop after req was released", name);
      other_err_cnt++;
    end
  endtask

  // Headers, then payload in order with last only on the final word
  task automatic check_packet(input string name, input dma_pkg::dma_desc_t d);
    dma_pkg::dma_flit_t exp;
    int n;
    n = int'(d.size) + 2;
    if (flit_log.size() != n) begin
      $display("mismatch in %s flit count: expected %0d, actual %0d",
               name, n, flit_log.size());
      mismatch_cnt++;
    end
    for (int i = 0; i < n && i < flit_log.size(); i++) begin
      exp.last = (i == n - 1);
      if (i == 0) begin
        exp.data = header0(d);
      end else if (i == 1) begin
        exp.data = d.raddr;
      end else begin
        exp.data = mem_word(d.laddr + 32'(4 * (i - 2)));
      end
      check_flit(name, exp, flit_log[i]);
    end
  endtask

  // Acked bus cycles; a burst ends early exactly where stb pauses next
  task automatic check_bus(input string name, input dma_pkg::dma_desc_t d);
    dma_pkg::wb_req_t exp;
    if (wb_log.size() != int'(d.size)) begin
      $display("mismatch in %s bus word count: expected %0d, actual %0d",
               name, d.size, wb_log.size());
      mismatch_cnt++;
    end
    foreach (wb_log[i]) begin
      exp.adr = d.laddr + 32'(4 * i);
      exp.sel = '1;
      exp.cyc = 1'b1;
      exp.stb = 1'b1;
      exp.we  = 1'b0;
      if (i == int'(d.size) - 1) begin
        exp.cti = 3'b111;
      end else if (i + 1 < gap_log.size() && gap_log[i + 1]) begin
        // Early end at the high-water mark
        exp.cti = 3'b111;
      end else begin
        exp.cti = 3'b010;
      end
      check_wb_req(name, exp, wb_log[i]);
    end
  endtask

  //////////////////////////////
  // Tests

  task automatic test_single_word();
    dma_pkg::dma_desc_t d;
    d.dest_tile = 8'h3C;
    d.raddr     = 32'h8000_1230;
    d.laddr     = 32'h0000_0400;
    d.size      = 8'd1;
    run_desc("single_word", d, 1'b0);
    check_packet("single_word", d);
    check_bus("single_word", d);
  endtask

  task automatic test_burst16();
    dma_pkg::dma_desc_t d;
    d.dest_tile = 8'h05;
    d.raddr     = 32'h4000_0000;
    d.laddr     = 32'h0001_0000;
    d.size      = 8'd16;
    run_desc("burst16", d, 1'b0);
    check_packet("burst16", d);
    check_bus("burst16", d);
  endtask

  task automatic test_backpressure();
    dma_pkg::dma_desc_t d;
    d.dest_tile = 8'hA7;
    d.raddr     = 32'h1234_5670;
    d.laddr     = 32'h0002_0100;
    d.size      = 8'd32;
    run_desc("backpressure", d, 1'b1);
    check_packet("backpressure", d);
    check_bus("backpressure", d);
  endtask

  task automatic test_wait_states();
    dma_pkg::dma_desc_t d;
    d.dest_tile = 8'h11;
    d.raddr     = 32'hCAFE_0000;
    d.laddr     = 32'h0000_0FF0;
    d.size      = 8'd10;
    wait_states = 4'd2;
    run_desc("wait_states", d, 1'b0);
    wait_states = 4'd0;
    check_packet("wait_states", d);
    check_bus("wait_states", d);
  endtask

  task automatic test_back_to_back();
    dma_pkg::dma_desc_t d;
    for (int k = 0; k < 3; k++) begin
      make_random_desc(d);
      run_desc($sformatf("back_to_back_%0d", k), d, 1'b0);
      check_packet($sformatf("back_to_back_%0d", k), d);
      check_bus($sformatf("back_to_back_%0d", k), d);
    end
  endtask

  initial begin
    rst           = 1'b1;
    desc_req      = 1'b0;
    desc          = '0;
    flit_ready    = 1'b1;
    wait_states   = 4'd0;
    lcg_state     = 32'h227b_f378;
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_single_word();
    test_burst16();
    test_backpressure();
    test_wait_states();
    test_back_to_back();
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt + other_err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/wb_mem_model.sv */
/*
 * Wishbone slave model for the DMA testbench, reads only.
 * Data is the byte address XOR A5A5_0000; no storage behind it.
 * Ack comes after wait_states_i idle cycles, at once for zero wait states.
 */

`default_nettype none

`include "dma_config.svh"

module wb_mem_model (
  input  wire                        clk,
  input  wire                        rst,
  input  wire dma_pkg::wb_req_t      wb_req_i,
  input  wire [3:0]                  wait_states_i,
  output logic [`DMA_DATA_WIDTH-1:0] wb_dat_o,
  output logic                       wb_ack_o
);

  logic [3:0] wait_cnt_q;
  logic       req_live;

  // A bus cycle is pending while cyc and stb are both high
  assign req_live = wb_req_i.cyc && wb_req_i.stb;

  // Ack on the cycle the wait count reaches its setting
  assign wb_ack_o = req_live && (wait_cnt_q == wait_states_i);

  // Address derived read data
  assign wb_dat_o = req_live ? (wb_req_i.adr ^ 32'hA5A5_0000) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt_q <= '0;
    end else if (req_live && !wb_ack_o) begin
      wait_cnt_q <= wait_cnt_q + 4'd1;
    end else begin
      // Each acked word starts a fresh wait
      wait_cnt_q <= '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/dma_config.svh */
/*
 * Widths and sizes shared by the local-to-remote DMA read path.
 * Transfers are whole aligned words; size counts words from 1 to 255.
 * The FIFO needs at least 3 entries for clean burst termination.
 */

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Bus and word widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32
`define DMA_SIZE_WIDTH 8
`define DMA_TILE_WIDTH 8
`define DMA_FIFO_DEPTH 3

// Header flit 0 field positions
`define DMA_HDR_TILE_LSB 24
`define DMA_HDR_SIZE_LSB 0

`endif

/* verilog/dma_l2r_top.sv */
/*
 * Local-to-remote DMA read path: intake, Wishbone fetch, NoC packetizer.
 * One descriptor in flight at a time; reads only.
 */

`default_nettype none

`include "dma_config.svh"

module dma_l2r_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       desc_req_i,
  input  wire dma_pkg::dma_desc_t   desc_i,
  output logic                      desc_ack_o,
  output dma_pkg::wb_req_t          wb_req_o,
  input  wire [`DMA_DATA_WIDTH-1:0] wb_dat_i,
  input  wire                       wb_ack_i,
  output logic                      flit_valid_o,
  output dma_pkg::dma_flit_t        flit_o,
  input  wire                       flit_ready_i
);

  dma_pkg::dma_desc_t         cur_desc;
  logic                       start;
  logic                       done;
  // Fetch to packetizer word stream
  logic                       word_valid;
  logic [`DMA_DATA_WIDTH-1:0] word_data;
  logic                       word_ready;

  dma_req_intake u_intake (
    .clk        (clk),
    .rst        (rst),
    .desc_req_i (desc_req_i),
    .desc_i     (desc_i),
    .desc_ack_o (desc_ack_o),
    .done_i     (done),
    .start_o    (start),
    .cur_desc_o (cur_desc)
  );

  dma_wb_read_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .desc_i       (cur_desc),
    .wb_req_o     (wb_req_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .word_ready_i (word_ready)
  );

  dma_noc_packetizer u_packetizer (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .desc_i       (cur_desc),
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .word_ready_o (word_ready),
    .flit_valid_o (flit_valid_o),
    .flit_o       (flit_o),
    .flit_ready_i (flit_ready_i),
    .done_o       (done)
  );

endmodule

`default_nettype wire

/* verilog/dma_noc_packetizer.sv */
/*
 * Sends header 0, header 1 and size payload flits with valid/ready.
 * Flit output is registered; the last payload flit carries last.
 * done_o pulses in the cycle that flit is accepted.
 */

`default_nettype none

`include "dma_config.svh"

module dma_noc_packetizer (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  input  wire dma_pkg::dma_desc_t   desc_i,
  input  wire                       word_valid_i,
  input  wire [`DMA_DATA_WIDTH-1:0] word_data_i,
  output logic                      word_ready_o,
  output logic                      flit_valid_o,
  output dma_pkg::dma_flit_t        flit_o,
  input  wire                       flit_ready_i,
  output logic                      done_o
);

  localparam int SW = `DMA_SIZE_WIDTH;

  // ST_HDR has header 0 on the output, ST_PAY starts with header 1
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_PAY
  } state_t;

  state_t             state_q;
  logic [SW-1:0]      cnt_q;
  logic               flit_valid_q;
  dma_pkg::dma_flit_t flit_q;
  logic               flit_take;
  logic               word_take;
  logic               last_word;
  logic               all_loaded;

  assign flit_take  = flit_valid_q && flit_ready_i;
  assign all_loaded = (cnt_q == desc_i.size);
  assign last_word  = (cnt_q == desc_i.size - SW'(1));

  // Take a word when the output slot is free or being emptied
  assign word_ready_o = (state_q == ST_PAY) && !all_loaded &&
                        (!flit_valid_q || flit_ready_i);
  assign word_take    = word_valid_i && word_ready_o;
  assign done_o       = flit_take && flit_q.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      flit_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q      <= ST_HDR;
            cnt_q        <= '0;
            flit_valid_q <= 1'b1;
          end
        end
        ST_HDR: if (flit_take) state_q <= ST_PAY;
        ST_PAY: begin
          if (word_take) begin
            flit_valid_q <= 1'b1;
            cnt_q        <= cnt_q + SW'(1);
          end else if (flit_take) begin
            flit_valid_q <= 1'b0;
          end
          if (done_o) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Flit payload register
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && start_i) begin
      flit_q.last <= 1'b0;
      flit_q.data <= dma_pkg::hdr0_word(desc_i);
    end else if (state_q == ST_HDR && flit_take) begin
      flit_q.last <= 1'b0;
      flit_q.data <= desc_i.raddr;
    end else if (word_take) begin
      flit_q.last <= last_word;
      flit_q.data <= word_data_i;
    end
  end

  assign flit_valid_o = flit_valid_q;
  assign flit_o       = flit_q;

  // A stalled flit stays offered and unchanged
  a_flit_hold: assert property (@(posedge clk) disable iff (rst)
    (flit_valid_o && !flit_ready_i) |=> (flit_valid_o && $stable(flit_o)));

endmodule

`default_nettype wire

/* verilog/dma_pkg.sv */
/*
 * Types of the DMA read path: descriptor, network flit, Wishbone request.
 * Header flit 0 holds dest_tile in 31:24 and size in 7:0, other bits zero.
 * Header flit 1 holds the remote address. Payload flits follow in order.
 */

`default_nettype none

`include "dma_config.svh"

package dma_pkg;

  // Transfer descriptor as handed over by the control agent
  typedef struct packed {
    logic [`DMA_TILE_WIDTH-1:0] dest_tile;
    logic [`DMA_ADDR_WIDTH-1:0] raddr;
    logic [`DMA_ADDR_WIDTH-1:0] laddr;
    logic [`DMA_SIZE_WIDTH-1:0] size;
  } dma_desc_t;

  // One network flit, last marks the end of a packet
  typedef struct packed {
    logic                       last;
    logic [`DMA_DATA_WIDTH-1:0] data;
  } dma_flit_t;

  // Wishbone initiator outputs, read only
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0]   adr;
    logic [`DMA_DATA_WIDTH/8-1:0] sel;
    logic                         cyc;
    logic                         stb;
    logic                         we;
    logic [2:0]                   cti;
  } wb_req_t;

  // Builds header flit 0 from a descriptor
  function automatic logic [`DMA_DATA_WIDTH-1:0] hdr0_word(dma_desc_t desc);
    logic [`DMA_DATA_WIDTH-1:0] word;
    word = '0;
    word[`DMA_HDR_TILE_LSB +: `DMA_TILE_WIDTH] = desc.dest_tile;
    word[`DMA_HDR_SIZE_LSB +: `DMA_SIZE_WIDTH] = desc.size;
    return word;
  endfunction

endpackage

`default_nettype wire

/* verilog/dma_req_intake.sv */
/*
 * Four-phase req/ack intake for one transfer descriptor.
 * desc_i must stay stable while req is high.
 * Ack drops the cycle after req drops; a new request needs ack low first.
 */

`default_nettype none

module dma_req_intake (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     desc_req_i,
  input  wire dma_pkg::dma_desc_t desc_i,
  output logic                    desc_ack_o,
  input  wire                     done_i,
  output logic                    start_o,
  output dma_pkg::dma_desc_t      cur_desc_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACKED
  } state_t;

  state_t             state_q;
  logic               start_q;
  dma_pkg::dma_desc_t desc_q;
  logic               desc_take;

  // New request seen while nothing is pending
  assign desc_take = (state_q == ST_IDLE) && desc_req_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      start_q <= 1'b0;
    end else begin
      // Start is a single cycle pulse
      start_q <= desc_take;
      case (state_q)
        ST_IDLE: if (desc_take) state_q <= ST_BUSY;
        // Packet fully sent, raise ack next cycle
        ST_BUSY: if (done_i) state_q <= ST_ACKED;
        // Hold ack until the agent drops req
        ST_ACKED: if (!desc_req_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Descriptor capture
  always_ff @(posedge clk) begin
    if (desc_take) begin
      desc_q <= desc_i;
    end
  end

  assign desc_ack_o = (state_q == ST_ACKED);
  assign start_o    = start_q;
  assign cur_desc_o = desc_q;

  // Agent keeps the descriptor steady during the transfer
  a_desc_stable: assert property (@(posedge clk) disable iff (rst)
    (desc_req_i && state_q == ST_BUSY) |-> $stable(desc_i));

endmodule

`default_nettype wire

/* verilog/dma_wb_read_fetch.sv */
/*
 * Wishbone incrementing burst reader feeding a 3-entry shift FIFO.
 * Bursts end with cti 111 when the FIFO nears full and restart later.
 * Only full aligned words are read; desc_i must hold during the transfer.
 */

`default_nettype none

`include "dma_config.svh"

module dma_wb_read_fetch (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        start_i,
  input  wire dma_pkg::dma_desc_t    desc_i,
  output dma_pkg::wb_req_t           wb_req_o,
  input  wire [`DMA_DATA_WIDTH-1:0]  wb_dat_i,
  input  wire                        wb_ack_i,
  output logic                       word_valid_o,
  output logic [`DMA_DATA_WIDTH-1:0] word_data_o,
  input  wire                        word_ready_i
);

  localparam int AW    = `DMA_ADDR_WIDTH;
  localparam int DW    = `DMA_DATA_WIDTH;
  localparam int SW    = `DMA_SIZE_WIDTH;
  localparam int DEPTH = `DMA_FIFO_DEPTH;

  localparam logic [2:0] CTI_INCR = 3'b010;
  localparam logic [2:0] CTI_END  = 3'b111;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_WAIT
  } state_t;

  state_t        state_q;
  state_t        state_d;
  logic [SW-1:0] cnt_q;
  logic [SW-1:0] cnt_d;
  logic          last_word;

  // FIFO storage, entry 0 is the head
  logic [DEPTH-1:0][DW-1:0] fifo_q;
  logic [DEPTH-1:0][DW-1:0] fifo_d;
  // One-hot write position, top bit marks full
  logic [DEPTH:0]           fifo_pos_q;
  logic [DEPTH-1:0]         wr_pos;
  logic                     fifo_push;
  logic                     fifo_pop;
  logic                     fifo_empty;
  logic                     fifo_full;
  logic                     fifo_ready;

  //////////////////////////////
  // FIFO

  assign fifo_empty = fifo_pos_q[0];
  assign fifo_full  = fifo_pos_q[DEPTH];
  // High-water mark, one free slot kept for the word still in flight
  assign fifo_ready = ~|fifo_pos_q[DEPTH:2];
  assign fifo_pop   = word_valid_o && word_ready_i;

  assign word_valid_o = !fifo_empty;
  assign word_data_o  = fifo_q[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_pos_q <= {{DEPTH{1'b0}}, 1'b1};
    end else if (fifo_push && !fifo_pop) begin
      fifo_pos_q <= fifo_pos_q << 1;
    end else if (fifo_pop && !fifo_push) begin
      fifo_pos_q <= fifo_pos_q >> 1;
    end
  end

  // Pop shifts everything down, push lands on the free slot after the shift
  always_comb begin
    fifo_d = fifo_q;
    wr_pos = fifo_pos_q[DEPTH-1:0];
    if (fifo_pop) begin
      fifo_d = fifo_q >> DW;
      wr_pos = fifo_pos_q[DEPTH:1];
    end
    for (int i = 0; i < DEPTH; i++) begin
      if (fifo_push && wr_pos[i]) begin
        fifo_d[i] = wb_dat_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    fifo_q <= fifo_d;
  end

  //////////////////////////////
  // Wishbone burst FSM

  assign last_word = (cnt_q == desc_i.size - SW'(1));

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    fifo_push    = 1'b0;
    wb_req_o.adr = '0;
    // Reads of whole words only
    wb_req_o.sel = '1;
    wb_req_o.we  = 1'b0;
    wb_req_o.cyc = 1'b0;
    wb_req_o.stb = 1'b0;
    wb_req_o.cti = 3'b000;
    case (state_q)
      ST_IDLE: begin
        cnt_d = '0;
        // FIFO is empty here, go straight to the bus
        if (start_i) state_d = ST_DATA;
      end
      ST_DATA: begin
        wb_req_o.cyc = 1'b1;
        wb_req_o.stb = 1'b1;
        // Word index to byte address
        wb_req_o.adr = desc_i.laddr + AW'({cnt_q, 2'b00});
        // End the burst on the final word or when storage runs short
        wb_req_o.cti = (last_word || !fifo_ready) ? CTI_END : CTI_INCR;
        if (wb_ack_i) begin
          fifo_push = 1'b1;
          cnt_d     = cnt_q + SW'(1);
          if (last_word) begin
            state_d = ST_IDLE;
          end else if (!fifo_ready) begin
            state_d = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        // Restart once the packetizer drains an entry
        if (fifo_ready) state_d = ST_DATA;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  //////////////////////////////
  // Checks

  // Strobe implies cycle, and an unacked request is held unchanged
  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    (wb_req_o.stb && !wb_ack_i) |=>
      (wb_req_o.stb && wb_req_o.cyc && $stable(wb_req_o.adr)));

  // Burst termination leaves room for every acked word
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (fifo_push && !fifo_pop) |-> !fifo_full);

  // Position never shifts out at either end, so no pop from empty
  a_pos_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot(fifo_pos_q));

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_req_intake.sv
verilog/dma_wb_read_fetch.sv
verilog/dma_noc_packetizer.sv
verilog/dma_l2r_top.sv
verification/wb_mem_model.sv
verification/dma_l2r_tb.sv
